// ==== verilog/sift_cfg.svh ====
// image size, DMA beat geometry and DDR offsets
// shared by the packages, the RTL and the testbench

`ifndef SIFT_CFG_SVH
`define SIFT_CFG_SVH

// image store, reduced for simulation
`define SIFT_IMG_PIXELS   4096               // 64 x 64 grey
`define SIFT_BEAT_BYTES   16                 // pixels per 128-bit beat
`define SIFT_IMG_BEATS    256                // beats per image

// DDR map
`define SIFT_DDR_AW       32
`define SIFT_RD_ADDR      32'h0030_0000      // image area
`define SIFT_WR_ADDR      32'h0050_0000      // result area

`endif

// ==== verilog/sift_img_pkg.sv ====
// image-side types: pixel, pixel address, DMA beat and beat index

package sift_img_pkg;

`include "sift_cfg.svh"

    typedef logic [7:0]                      pixel_t;
    typedef logic [17:0]                     img_addr_t;     // same width as the core's address bus
    typedef logic [`SIFT_BEAT_BYTES*8-1:0]   beat_t;
    typedef logic [7:0]                      beat_idx_t;
    typedef logic [`SIFT_DDR_AW-1:0]         ddr_addr_t;

endpackage

// ==== verilog/sift_feat_pkg.sv ====
// feature record written back to DDR, load controller state encoding

package sift_feat_pkg;

    // one 64-bit result word, msb first
    typedef struct packed {
        logic [7:0]  mag;
        logic [7:0]  dir;           // 6-bit direction, upper 2 bits zero
        logic [21:0] rsvd_hi;
        logic        stage2;
        logic        kp;
        logic [5:0]  rsvd_lo;
        logic [17:0] kp_addr;
    } feature_t;

    typedef enum logic [1:0] {
        IDLE    = 2'b00,
        LOAD    = 2'b01,
        PROCESS = 2'b11
    } load_state_t;

endpackage

// ==== verilog/load_ctrl.sv ====
// image load controller: read request, beat counter and core run/flush

`include "sift_cfg.svh"

module load_ctrl
    import sift_img_pkg::*;
    import sift_feat_pkg::*;
(
    input  logic                      sys_clk,
    input  logic                      sys_rstn,

    input  logic                      i_start,
    input  logic                      i_rd_valid,
    input  logic                      i_core_done,

    output logic                      o_rd_req,
    output ddr_addr_t                 o_rd_addr,
    output logic [$bits(beat_idx_t):0] o_rd_beats,
    output beat_idx_t                 o_wr_beat_idx,
    output logic                      o_core_run,
    output logic                      o_flush
);

    localparam beat_idx_t LAST_BEAT = beat_idx_t'(`SIFT_IMG_BEATS - 1);

    load_state_t state;
    beat_idx_t   beat_cnt;
    logic        rd_req_q;

    // ============================================================
    // main FSM
    // ============================================================
    always_ff @(posedge sys_clk or negedge sys_rstn) begin
        if (!sys_rstn) begin
            state    <= IDLE;
            beat_cnt <= '0;
            rd_req_q <= 1'b0;
        end else begin
            rd_req_q <= 1'b0;
            case (state)
                IDLE: begin
                    beat_cnt <= '0;
                    if (i_start) begin
                        rd_req_q <= 1'b1;       // single request for whole image
                        state    <= LOAD;
                    end
                end
                LOAD: begin
                    if (i_rd_valid) begin
                        beat_cnt <= beat_cnt + 1'b1;    // wraps to 0 after last beat
                        if (beat_cnt == LAST_BEAT)
                            state <= PROCESS;
                    end
                end
                PROCESS: begin
                    if (i_core_done)
                        state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // request fields are fixed for this image geometry
    assign o_rd_req      = rd_req_q;
    assign o_rd_addr     = `SIFT_RD_ADDR;
    assign o_rd_beats    = ($bits(beat_idx_t) + 1)'(`SIFT_IMG_BEATS);
    assign o_wr_beat_idx = beat_cnt;

    assign o_core_run = (state == PROCESS);
    assign o_flush    = (state == PROCESS) && i_core_done;   // drains a half-filled beat

endmodule

// ==== verilog/image_ram.sv ====
// image store: beat-wide write port, pixel-wide registered read port

`include "sift_cfg.svh"

module image_ram
    import sift_img_pkg::*;
(
    input  logic      sys_clk,

    input  logic      i_wr_en,
    input  beat_idx_t i_wr_idx,
    input  beat_t     i_wr_data,

    input  img_addr_t i_rd_addr,
    output pixel_t    o_rd_pixel
);

    localparam int WORDS  = `SIFT_IMG_PIXELS / `SIFT_BEAT_BYTES;
    localparam int SEL_W  = $clog2(`SIFT_BEAT_BYTES);
    localparam int WORD_W = $clog2(WORDS);

    beat_t             mem [WORDS];
    beat_t             rd_word_q;
    logic [SEL_W-1:0]  rd_sel_q;

    always_ff @(posedge sys_clk) begin
        if (i_wr_en)
            mem[i_wr_idx] <= i_wr_data;
    end

    // read-first, new data visible next cycle
    always_ff @(posedge sys_clk) begin
        rd_word_q <= mem[i_rd_addr[SEL_W +: WORD_W]];
        rd_sel_q  <= i_rd_addr[SEL_W-1:0];
    end

    // byte k of a beat is pixel 16*i+k
    assign o_rd_pixel = rd_word_q[rd_sel_q*8 +: 8];

endmodule

// ==== verilog/feature_packer.sv ====
// feature packer: two 64-bit features per 128-bit DMA write beat
// result address walks up from the result area base

`include "sift_cfg.svh"

module feature_packer
    import sift_img_pkg::*;
    import sift_feat_pkg::*;
(
    input  logic      sys_clk,
    input  logic      sys_rstn,

    input  logic      i_restart,
    input  logic      i_run,
    input  logic      i_flush,
    input  logic      i_feat_valid,
    input  feature_t  i_feat,

    output logic      o_wr_valid,
    output ddr_addr_t o_wr_addr,
    output beat_t     o_wr_data
);

    localparam ddr_addr_t ADDR_STEP = ddr_addr_t'(`SIFT_BEAT_BYTES);

    logic      accept;
    logic      emit;
    logic      held;
    feature_t  lo_q;           // first of a pair
    ddr_addr_t next_addr;
    beat_t     beat_d;

    assign accept = i_run && i_feat_valid;

    // ============================================================
    // pairing
    // ============================================================
    always_comb begin
        emit   = 1'b0;
        beat_d = {lo_q, i_feat};
        if (accept && held) begin
            emit   = 1'b1;
            beat_d = {i_feat, lo_q};
        end else if (accept && i_flush) begin
            emit   = 1'b1;
            beat_d = {64'd0, i_feat};   // lone feature on the way out
        end else if (i_flush && held) begin
            emit   = 1'b1;
            beat_d = {64'd0, lo_q};
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rstn) begin
        if (!sys_rstn) begin
            held       <= 1'b0;
            o_wr_valid <= 1'b0;
            next_addr  <= `SIFT_WR_ADDR;
        end else begin
            o_wr_valid <= emit;
            if (i_restart) begin
                held      <= 1'b0;
                next_addr <= `SIFT_WR_ADDR;
            end else if (emit) begin
                held      <= 1'b0;
                next_addr <= next_addr + ADDR_STEP;
            end else if (accept) begin
                held <= 1'b1;
            end
        end
    end

    // payload
    always_ff @(posedge sys_clk) begin
        if (accept && !held)
            lo_q <= i_feat;
        if (emit) begin
            o_wr_addr <= next_addr;
            o_wr_data <= beat_d;
        end
    end

endmodule

// ==== verilog/sift_mem_path.sv ====
// memory-side datapath around the SIFT core
// load controller, image RAM and result packer

module sift_mem_path
    import sift_img_pkg::*;
    import sift_feat_pkg::*;
(
    input  logic                       sys_clk,
    input  logic                       sys_rstn,

    // command
    input  logic                       i_start,

    // DMA read side
    output logic                       o_rd_req,
    output ddr_addr_t                  o_rd_addr,
    output logic [$bits(beat_idx_t):0] o_rd_beats,
    input  logic                       i_rd_valid,
    input  beat_t                      i_rd_data,

    // SIFT core side
    input  img_addr_t                  i_core_addr,
    output pixel_t                     o_core_pixel,
    output logic                       o_core_run,
    input  logic                       i_feat_valid,
    input  feature_t                   i_feat,
    input  logic                       i_core_done,

    // DMA write side
    output logic                       o_wr_valid,
    output ddr_addr_t                  o_wr_addr,
    output beat_t                      o_wr_data
);

    beat_idx_t wr_beat_idx;
    logic      flush;

    // ============================================================
    // control
    // ============================================================
    load_ctrl u_load_ctrl (
        .sys_clk       (sys_clk),
        .sys_rstn      (sys_rstn),
        .i_start       (i_start),
        .i_rd_valid    (i_rd_valid),
        .i_core_done   (i_core_done),
        .o_rd_req      (o_rd_req),
        .o_rd_addr     (o_rd_addr),
        .o_rd_beats    (o_rd_beats),
        .o_wr_beat_idx (wr_beat_idx),
        .o_core_run    (o_core_run),
        .o_flush       (flush)
    );

    // ============================================================
    // image store and result path
    // ============================================================
    image_ram u_image_ram (
        .sys_clk    (sys_clk),
        .i_wr_en    (i_rd_valid),      // every returned beat is stored
        .i_wr_idx   (wr_beat_idx),
        .i_wr_data  (i_rd_data),
        .i_rd_addr  (i_core_addr),
        .o_rd_pixel (o_core_pixel)
    );

    feature_packer u_feature_packer (
        .sys_clk      (sys_clk),
        .sys_rstn     (sys_rstn),
        .i_restart    (o_rd_req),      // new image, rewind result area
        .i_run        (o_core_run),
        .i_flush      (flush),
        .i_feat_valid (i_feat_valid),
        .i_feat       (i_feat),
        .o_wr_valid   (o_wr_valid),
        .o_wr_addr    (o_wr_addr),
        .o_wr_data    (o_wr_data)
    );

endmodule

// ==== testbench/tb_sift_model.svh ====
// reference model for the memory datapath testbench
// image copy, feature pairing into write beats, and the checks against them

`ifndef TB_SIFT_MODEL_SVH
`define TB_SIFT_MODEL_SVH

pixel_t    model_img [`SIFT_IMG_PIXELS];
beat_t     exp_data [$];
ddr_addr_t exp_addr [$];
feature_t  model_half;          // first of a pair, waiting
logic      model_has_half;
ddr_addr_t model_wr_addr;

function automatic void fail_check(string msg);
    $display("CHECK FAILED at %0t: %s", $time, msg);
    err_cnt++;
endfunction

// a new read request rewinds the result area
function automatic void model_restart();
    model_has_half = 1'b0;
    model_wr_addr  = `SIFT_WR_ADDR;
endfunction

function automatic void push_beat(beat_t b);
    exp_data.push_back(b);
    exp_addr.push_back(model_wr_addr);
    model_wr_addr = model_wr_addr + 32'(`SIFT_BEAT_BYTES);
endfunction

// first feature low, second high
function automatic void model_feature(feature_t f);
    if (model_has_half)
        push_beat({f, model_half});
    else
        model_half = f;
    model_has_half = !model_has_half;
endfunction

function automatic void model_flush();
    if (model_has_half)
        push_beat({64'd0, model_half});    // lone feature, zero high half
    model_has_half = 1'b0;
endfunction

// byte k of beat i is pixel 16*i+k, built by shifting in from the top
function automatic beat_t image_beat(int idx);
    beat_t b;
    b = '0;
    for (int k = 0; k < `SIFT_BEAT_BYTES; k++)
        b = {model_img[12'(idx * `SIFT_BEAT_BYTES + k)], b[$bits(beat_t)-1:8]};
    return b;
endfunction

function automatic void check_beat(ddr_addr_t addr, beat_t data);
    if (exp_data.size() == 0) begin
        $display("error at %0t: write beat to %h arrived with none expected", $time, addr);
        err_cnt++;
        return;
    end
    if (addr !== exp_addr[0] || data !== exp_data[0])
        fail_check($sformatf("write beat %h at %h, expected %h at %h",
                             data, addr, exp_data[0], exp_addr[0]));
    void'(exp_data.pop_front());
    void'(exp_addr.pop_front());
endfunction

function automatic void check_pixel(img_addr_t addr, pixel_t got);
    if (got !== model_img[addr[11:0]])
        fail_check($sformatf("pixel %0d read %h, expected %h",
                             addr, got, model_img[addr[11:0]]));
endfunction

`endif

// ==== testbench/tb_sift_mem_path.sv ====
// testbench for the SIFT memory datapath
// random images, core reads and feature streams against a reference model

`include "sift_cfg.svh"

module tb_sift_mem_path
    import sift_img_pkg::*;
    import sift_feat_pkg::*;
();

    localparam int CLK_HALF   = 10;
    localparam int WAIT_LIMIT = 4000;

    logic                       sys_clk, sys_rstn;
    logic                       i_start, i_rd_valid, i_feat_valid, i_core_done;
    beat_t                      i_rd_data;
    img_addr_t                  i_core_addr;
    feature_t                   i_feat;
    logic                       o_rd_req, o_core_run, o_wr_valid;
    ddr_addr_t                  o_rd_addr, o_wr_addr;
    logic [$bits(beat_idx_t):0] o_rd_beats;
    pixel_t                     o_core_pixel;
    beat_t                      o_wr_data;

    int          err_cnt     = 0;
    int          case_errs   = 0;
    int          cases_ok    = 0;
    int          cases_bad   = 0;
    int          rd_req_cnt  = 0;
    int          wr_beat_cnt = 0;
    int          mark;
    int          nfeat;

    `include "tb_sift_model.svh"

    initial begin
        sys_clk = 1'b0;
        forever #CLK_HALF sys_clk = ~sys_clk;
    end

    sift_mem_path dut (.*);

    // ============================================================
    // output monitor
    // ============================================================
    always @(negedge sys_clk) begin
        if (sys_rstn && o_rd_req) begin
            rd_req_cnt++;
            if (o_rd_addr !== `SIFT_RD_ADDR || o_rd_beats !== 9'(`SIFT_IMG_BEATS))
                fail_check($sformatf("read request %h/%0d", o_rd_addr, o_rd_beats));
        end
        if (sys_rstn && o_wr_valid) begin
            wr_beat_cnt++;
            check_beat(o_wr_addr, o_wr_data);
        end
    end

    task automatic report_timeout(string why);
        $display("timeout at %0t: %s", $time, why);
        err_cnt++;
    endtask

    task automatic end_case(string name);
        if (err_cnt == case_errs) begin
            $display("case %s: ok", name);
            cases_ok++;
        end else begin
            $display("case %s: %0d errors", name, err_cnt - case_errs);
            cases_bad++;
        end
        case_errs = err_cnt;
    endtask

    task automatic start_image();
        int n;
        @(posedge sys_clk);
        i_start <= 1'b1;
        @(posedge sys_clk);
        i_start <= 1'b0;
        n = 0;
        @(negedge sys_clk);
        while (!o_rd_req && n < WAIT_LIMIT) begin
            @(negedge sys_clk);
            n++;
        end
        if (!o_rd_req)
            report_timeout("read request never issued after start");
        model_restart();
    endtask

    // stream a new random image with gaps and maybe a stray start mid-load
    task automatic load_image(bit poke_start);
        int gap;
        for (int p = 0; p < `SIFT_IMG_PIXELS; p++)
            model_img[12'(p)] = pixel_t'($urandom);
        for (int i = 0; i < `SIFT_IMG_BEATS; i++) begin
            gap = $urandom_range(0, 3);
            repeat (gap) begin
                @(posedge sys_clk);
                i_rd_valid <= 1'b0;
                i_start    <= 1'b0;
            end
            @(posedge sys_clk);
            i_rd_valid <= 1'b1;
            i_rd_data  <= image_beat(i);
            i_start    <= poke_start && (i == 100);
            @(negedge sys_clk);
            if (o_core_run)
                fail_check($sformatf("core running before beat %0d was taken", i));
        end
        @(posedge sys_clk);
        i_rd_valid <= 1'b0;
        i_start    <= 1'b0;
    endtask

    task automatic wait_run(logic level);
        int n;
        n = 0;
        @(negedge sys_clk);
        while (o_core_run !== level && n < WAIT_LIMIT) begin
            @(negedge sys_clk);
            n++;
        end
        if (o_core_run !== level)
            report_timeout($sformatf("core run never went to %0b", level));
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        @(negedge sys_clk);
        while (exp_data.size() != 0 && n < WAIT_LIMIT) begin
            @(negedge sys_clk);
            n++;
        end
        if (exp_data.size() != 0)
            report_timeout($sformatf("%0d write beats never arrived", exp_data.size()));
    endtask

    task automatic read_pixels(int count);
        img_addr_t a;
        for (int i = 0; i < count; i++) begin
            a = img_addr_t'($urandom_range(0, `SIFT_IMG_PIXELS - 1));
            @(posedge sys_clk);
            i_core_addr <= a;
            @(posedge sys_clk);
            @(negedge sys_clk);            // one cycle after the address
            check_pixel(a, o_core_pixel);
        end
    endtask

    task automatic send_features(int count, bit running);
        feature_t f;
        int       gap;
        for (int i = 0; i < count; i++) begin
            gap = $urandom_range(0, 2);
            repeat (gap) begin
                @(posedge sys_clk);
                i_feat_valid <= 1'b0;
            end
            // mag, dir (6 bits), zeros, stage2/kp flags, zeros, keypoint address
            f = {8'($urandom), 2'b00, 6'($urandom), 22'd0, 2'($urandom), 6'd0, 18'($urandom)};
            @(posedge sys_clk);
            i_feat_valid <= 1'b1;
            i_feat       <= f;
            if (running)
                model_feature(f);
        end
        @(posedge sys_clk);
        i_feat_valid <= 1'b0;
    endtask

    task automatic finish_core();
        model_flush();
        @(posedge sys_clk);
        i_core_done <= 1'b1;
        @(posedge sys_clk);
        i_core_done <= 1'b0;
        wait_drain();
        wait_run(1'b0);
    endtask

    // ============================================================
    // test sequence
    // ============================================================
    initial begin
        void'($urandom(32'heafc_7e81));
        sys_rstn     = 1'b0;
        i_start      = 1'b0;
        i_rd_valid   = 1'b0;
        i_rd_data    = '0;
        i_core_addr  = '0;
        i_feat_valid = 1'b0;
        i_feat       = '0;
        i_core_done  = 1'b0;
        model_restart();
        repeat (8) @(posedge sys_clk);
        sys_rstn <= 1'b1;

        @(negedge sys_clk);
        if (o_rd_req || o_core_run || o_wr_valid)
            fail_check("request, run or write strobe active after reset");
        mark = rd_req_cnt;
        start_image();
        load_image(1'b0);
        wait_run(1'b1);
        @(posedge sys_clk);
        if (rd_req_cnt != mark + 1)
            fail_check($sformatf("%0d read requests for one start", rd_req_cnt - mark));
        end_case("1 reset, request and load");

        read_pixels(200);
        end_case("2 pixel reads");

        mark  = wr_beat_cnt;
        nfeat = 2 * $urandom_range(8, 16);
        send_features(nfeat, 1'b1);
        wait_drain();
        if (wr_beat_cnt != mark + nfeat / 2)
            fail_check($sformatf("%0d beats for %0d features", wr_beat_cnt - mark, nfeat));
        end_case("3 feature pairs");

        mark  = wr_beat_cnt;
        nfeat = 2 * $urandom_range(2, 6) + 1;
        send_features(nfeat, 1'b1);
        finish_core();
        if (wr_beat_cnt != mark + (nfeat + 1) / 2)
            fail_check($sformatf("%0d beats for %0d features", wr_beat_cnt - mark, nfeat));
        end_case("4 odd count and flush");

        mark = wr_beat_cnt;
        send_features(6, 1'b0);            // core idle so nothing is accepted
        repeat (3) @(posedge sys_clk);
        if (wr_beat_cnt != mark)
            fail_check("write beats produced while core not running");
        mark = rd_req_cnt;
        start_image();
        load_image(1'b1);
        wait_run(1'b1);
        @(posedge sys_clk);
        if (rd_req_cnt != mark + 1)
            fail_check("start during load gave another read request");
        read_pixels(100);
        send_features(9, 1'b1);
        finish_core();
        end_case("5 idle features, stray start, second run");

        $display("cases passed %0d, cases failed %0d, errors %0d",
                 cases_ok, cases_bad, err_cnt);
        if (err_cnt == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+verilog
+incdir+testbench
verilog/sift_img_pkg.sv
verilog/sift_feat_pkg.sv
verilog/load_ctrl.sv
verilog/image_ram.sv
verilog/feature_packer.sv
verilog/sift_mem_path.sv
testbench/tb_sift_mem_path.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the memory datapath testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sources.f --top-module tb_sift_mem_path -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_sift_mem_path)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^TEST PASS$"; then
    exit 0
fi
exit 1
